// ==== design/noc_router_cfg.svh ====
// NoC router configuration
// Widths and limits shared by the router input channel and its testbench

`ifndef NOC_ROUTER_CFG_SVH
`define NOC_ROUTER_CFG_SVH

// Bits per mesh coordinate
`define NOC_COORD_W 3

// Payload bits per flit
`define NOC_DATA_W 16

// Width of each per-port flit counter, wraps on overflow
`define NOC_CNT_W 8

// Longest packet in flits, the last flit is forced at this length
`define NOC_MAX_PKT_FLITS 4

// Output directions: eject, south, west, north, east
`define NOC_NUM_PORTS 5

`endif

// ==== design/noc_router_pkg.sv ====
// NoC router types
// Vector types for coordinates, payload, port masks and counters,
// plus the direction and route lock encodings

`include "noc_router_cfg.svh"

package noc_router_pkg;

  // One mesh coordinate
  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // Flit payload
  typedef logic [`NOC_DATA_W-1:0] payload_t;

  // One-hot output direction vector
  typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;

  // Per-port flit counter value
  typedef logic [`NOC_CNT_W-1:0] flit_cnt_t;

  // Output direction, the value is the bit index in port_mask_t
  typedef enum logic [2:0] {
    DIR_EJECT = 3'd0,
    DIR_SOUTH = 3'd1,
    DIR_WEST  = 3'd2,
    DIR_NORTH = 3'd3,
    DIR_EAST  = 3'd4
  } route_dir_e;

  // Route lock FSM, held locked between the head and the last flit
  typedef enum logic {
    LOCK_UNLOCKED = 1'b0,
    LOCK_LOCKED   = 1'b1
  } lock_state_e;

endpackage

// ==== design/flit_ingress.sv ====
// Flit ingress stage
// Registers each strobed flit and limits packets to a maximum length
// by forcing the last marker on the final allowed flit

`timescale 1ns/100ps

`include "noc_router_cfg.svh"

module flit_ingress
  import noc_router_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flit_valid_i,
  input  logic     flit_last_i,
  input  coord_t   flit_dst_x_i,
  input  coord_t   flit_dst_y_i,
  input  payload_t flit_data_i,
  output logic     in_valid_o,
  output logic     in_last_o,
  output coord_t   in_dst_x_o,
  output coord_t   in_dst_y_o,
  output payload_t in_data_o
);

  localparam int unsigned LEN_W = $clog2(`NOC_MAX_PKT_FLITS + 1);

  // Flits already accepted in the open packet
  logic [LEN_W-1:0] len_cnt_q;
  logic             len_limit;
  logic             last_eff;

  logic             in_valid_q;
  logic             in_last_q;
  coord_t           dst_x_q;
  coord_t           dst_y_q;
  payload_t         data_q;

  // Current flit is the last one the length limit allows
  assign len_limit = (len_cnt_q == LEN_W'(`NOC_MAX_PKT_FLITS - 1));
  assign last_eff  = flit_last_i | len_limit;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_valid_q <= 1'b0;
      in_last_q  <= 1'b0;
      len_cnt_q  <= '0;
    end else begin
      in_valid_q <= flit_valid_i;
      in_last_q  <= flit_valid_i & last_eff;
      if (flit_valid_i) begin
        // A flit leaving as last closes the packet
        if (last_eff) begin
          len_cnt_q <= '0;
        end else begin
          len_cnt_q <= len_cnt_q + 1'b1;
        end
      end
    end
  end

  // Destination and payload captured only with a flit
  always_ff @(posedge clk_i) begin
    if (flit_valid_i) begin
      dst_x_q <= flit_dst_x_i;
      dst_y_q <= flit_dst_y_i;
      data_q  <= flit_data_i;
    end
  end

  assign in_valid_o = in_valid_q;
  assign in_last_o  = in_last_q;
  assign in_dst_x_o = dst_x_q;
  assign in_dst_y_o = dst_y_q;
  assign in_data_o  = data_q;

endmodule

// ==== design/xy_route_select.sv ====
// XY route selector
// Dimension-ordered routing to one of five directions, with the head
// flit's route held for the body flits of a packet

`timescale 1ns/100ps

module xy_route_select
  import noc_router_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  coord_t     node_x_i,
  input  coord_t     node_y_i,
  input  logic       in_valid_i,
  input  logic       in_last_i,
  input  coord_t     in_dst_x_i,
  input  coord_t     in_dst_y_i,
  input  payload_t   in_data_i,
  output logic       sel_valid_o,
  output logic       sel_last_o,
  output payload_t   sel_data_o,
  output port_mask_t sel_mask_o
);

  route_dir_e  route_dir;
  port_mask_t  route_mask;

  lock_state_e lock_q;
  lock_state_e lock_d;
  port_mask_t  locked_mask_q;

  // X first, then Y, eject once both match
  always_comb begin
    if ((in_dst_x_i == node_x_i) && (in_dst_y_i == node_y_i)) begin
      route_dir = DIR_EJECT;
    end else if (in_dst_x_i == node_x_i) begin
      if (in_dst_y_i < node_y_i) begin
        route_dir = DIR_SOUTH;
      end else begin
        route_dir = DIR_NORTH;
      end
    end else begin
      if (in_dst_x_i < node_x_i) begin
        route_dir = DIR_WEST;
      end else begin
        route_dir = DIR_EAST;
      end
    end
  end

  // Direction value is the bit position in the mask
  always_comb begin
    route_mask            = '0;
    route_mask[route_dir] = 1'b1;
  end

  // Lock on a head flit that is not last, release on the last flit
  always_comb begin
    lock_d = lock_q;
    case (lock_q)
      LOCK_UNLOCKED: begin
        if (in_valid_i && !in_last_i) begin
          lock_d = LOCK_LOCKED;
        end
      end
      LOCK_LOCKED: begin
        if (in_valid_i && in_last_i) begin
          lock_d = LOCK_UNLOCKED;
        end
      end
      default: begin
        lock_d = LOCK_UNLOCKED;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= LOCK_UNLOCKED;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Head flit route, only read while locked
  always_ff @(posedge clk_i) begin
    if (in_valid_i && (lock_q == LOCK_UNLOCKED)) begin
      locked_mask_q <= route_mask;
    end
  end

  // Body flits ignore their own destination fields
  assign sel_mask_o  = (lock_q == LOCK_LOCKED) ? locked_mask_q : route_mask;

  assign sel_valid_o = in_valid_i;
  assign sel_last_o  = in_last_i;
  assign sel_data_o  = in_data_i;

endmodule

// ==== design/flit_egress.sv ====
// Flit egress stage
// Registers the routed flit onto a one-hot output strobe and keeps a
// wrapping count of the flits sent on each direction

`timescale 1ns/100ps

`include "noc_router_cfg.svh"

module flit_egress
  import noc_router_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          sel_valid_i,
  input  logic                          sel_last_i,
  input  payload_t                      sel_data_i,
  input  port_mask_t                    sel_mask_i,
  output port_mask_t                    out_valid_o,
  output logic                          out_last_o,
  output payload_t                      out_data_o,
  output flit_cnt_t [`NOC_NUM_PORTS-1:0] flit_count_o
);

  port_mask_t                     out_valid_q;
  logic                           out_last_q;
  payload_t                       out_data_q;
  flit_cnt_t [`NOC_NUM_PORTS-1:0] cnt_q;

  // Strobe exists only in the cycle after a valid flit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= '0;
      out_last_q  <= 1'b0;
    end else begin
      if (sel_valid_i) begin
        out_valid_q <= sel_mask_i;
      end else begin
        out_valid_q <= '0;
      end
      out_last_q <= sel_valid_i & sel_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_valid_i) begin
      out_data_q <= sel_data_i;
    end
  end

  // Counter steps on the same edge that raises its strobe bit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
        if (sel_valid_i && sel_mask_i[p]) begin
          cnt_q[p] <= cnt_q[p] + 1'b1;
        end
      end
    end
  end

  assign out_valid_o  = out_valid_q;
  assign out_last_o   = out_last_q;
  assign out_data_o   = out_data_q;
  assign flit_count_o = cnt_q;

endmodule

// ==== design/noc_router_top.sv ====
// NoC router input channel
// Ingress register, XY route selection and egress distribution with
// per-direction flit counters, two cycles from input to output

`timescale 1ns/100ps

`include "noc_router_cfg.svh"

module noc_router_top
  import noc_router_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          flit_valid_i,
  input  logic                          flit_last_i,
  input  coord_t                        flit_dst_x_i,
  input  coord_t                        flit_dst_y_i,
  input  payload_t                      flit_data_i,
  input  coord_t                        node_x_i,
  input  coord_t                        node_y_i,
  output port_mask_t                    out_valid_o,
  output logic                          out_last_o,
  output payload_t                      out_data_o,
  output flit_cnt_t [`NOC_NUM_PORTS-1:0] flit_count_o
);

  // Ingress to route selector
  logic       in_valid;
  logic       in_last;
  coord_t     in_dst_x;
  coord_t     in_dst_y;
  payload_t   in_data;

  // Route selector to egress
  logic       sel_valid;
  logic       sel_last;
  payload_t   sel_data;
  port_mask_t sel_mask;

  flit_ingress u_ingress (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flit_valid_i (flit_valid_i),
    .flit_last_i  (flit_last_i),
    .flit_dst_x_i (flit_dst_x_i),
    .flit_dst_y_i (flit_dst_y_i),
    .flit_data_i  (flit_data_i),
    .in_valid_o   (in_valid),
    .in_last_o    (in_last),
    .in_dst_x_o   (in_dst_x),
    .in_dst_y_o   (in_dst_y),
    .in_data_o    (in_data)
  );

  xy_route_select u_route_select (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .node_x_i    (node_x_i),
    .node_y_i    (node_y_i),
    .in_valid_i  (in_valid),
    .in_last_i   (in_last),
    .in_dst_x_i  (in_dst_x),
    .in_dst_y_i  (in_dst_y),
    .in_data_i   (in_data),
    .sel_valid_o (sel_valid),
    .sel_last_o  (sel_last),
    .sel_data_o  (sel_data),
    .sel_mask_o  (sel_mask)
  );

  flit_egress u_egress (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .sel_valid_i  (sel_valid),
    .sel_last_i   (sel_last),
    .sel_data_i   (sel_data),
    .sel_mask_i   (sel_mask),
    .out_valid_o  (out_valid_o),
    .out_last_o   (out_last_o),
    .out_data_o   (out_data_o),
    .flit_count_o (flit_count_o)
  );

endmodule

// ==== tb/noc_router_checker.sv ====
// Output strobe checker for the NoC router input channel
// One-hot strobes, quiet outputs in reset and a fixed two-cycle latency

`timescale 1ns/100ps

module noc_router_checker
  import noc_router_pkg::*;
(
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       flit_valid_i,
  input port_mask_t out_valid_i
);

  // Count of assertion failures
  int unsigned fail_count = 0;

  a_onehot: assert property (@(posedge clk_i) $onehot0(out_valid_i))
    else begin
      $error("out_valid_o has more than one bit set: %b", out_valid_i);
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> (out_valid_i == '0))
    else begin
      $error("out_valid_o is not zero while in reset: %b", out_valid_i);
      fail_count++;
    end

  // Two edges from the sampling edge of the flit to the strobe
  a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flit_valid_i |-> ##2 (out_valid_i != '0))
    else begin
      $error("no output strobe two cycles after an input flit");
      fail_count++;
    end

  a_no_spurious: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_i != '0) |-> $past(flit_valid_i, 2))
    else begin
      $error("output strobe without an input flit two cycles before");
      fail_count++;
    end

endmodule

bind noc_router_top noc_router_checker u_checker (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .flit_valid_i (flit_valid_i),
  .out_valid_i  (out_valid_o)
);

// ==== tb/noc_router_tb.sv ====
// NoC router testbench
// Directed flit table, a seeded random run and a mid-packet reset
// checked against a scoreboard built from the routing rules

`timescale 1ns/100ps

`include "noc_router_cfg.svh"

module noc_router_tb
  import noc_router_pkg::*;
();

  localparam int     CLK_PERIOD  = 4;
  localparam int     TIMEOUT_CYC = 20;
  localparam int     NUM_RANDOM  = 200;
  localparam coord_t NODE_X      = 3;
  localparam coord_t NODE_Y      = 3;
  // Driven at edge k and sampled at k+1, strobe raised at k+2 and seen in the low phase
  localparam time    LATENCY_NS  = 2 * CLK_PERIOD + CLK_PERIOD / 2;

  typedef struct packed {
    coord_t     dst_x;
    coord_t     dst_y;
    logic       last;
    payload_t   data;
    route_dir_e dir;
  } entry_t;

  typedef struct packed {
    port_mask_t  mask;
    logic        last;
    payload_t    data;
    logic [63:0] t_drive;
  } exp_flit_t;

  logic                           clk_i;
  logic                           arst_n_i;
  logic                           flit_valid_i;
  logic                           flit_last_i;
  coord_t                         flit_dst_x_i;
  coord_t                         flit_dst_y_i;
  payload_t                       flit_data_i;
  coord_t                         node_x_i;
  coord_t                         node_y_i;
  port_mask_t                     out_valid_o;
  logic                           out_last_o;
  payload_t                       out_data_o;
  flit_cnt_t [`NOC_NUM_PORTS-1:0] flit_count_o;

  entry_t     table_q[$];
  string      name_q[$];
  exp_flit_t  sb_q[$];
  // Reference state of the lock and length rules
  logic       ref_locked;
  route_dir_e ref_dir;
  int         ref_len;
  int         ref_cnt[`NOC_NUM_PORTS];
  int         seed;
  int         errors;
  int         tests;
  int         failed_tests;

  noc_router_top DUT (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flit_valid_i (flit_valid_i),
    .flit_last_i  (flit_last_i),
    .flit_dst_x_i (flit_dst_x_i),
    .flit_dst_y_i (flit_dst_y_i),
    .flit_data_i  (flit_data_i),
    .node_x_i     (node_x_i),
    .node_y_i     (node_y_i),
    .out_valid_o  (out_valid_o),
    .out_last_o   (out_last_o),
    .out_data_o   (out_data_o),
    .flit_count_o (flit_count_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic route_dir_e xy_dir(input coord_t dx, input coord_t dy);
    if (dx == NODE_X && dy == NODE_Y) begin
      return DIR_EJECT;
    end else if (dx == NODE_X) begin
      return (dy < NODE_Y) ? DIR_SOUTH : DIR_NORTH;
    end
    return (dx < NODE_X) ? DIR_WEST : DIR_EAST;
  endfunction

  task automatic clear_model();
    ref_locked = 1'b0;
    ref_len    = 0;
    foreach (ref_cnt[p]) begin
      ref_cnt[p] = 0;
    end
  endtask

  task automatic predict_flit(input coord_t dx, input coord_t dy, input logic last,
                              output route_dir_e dir, output logic eff_last);
    eff_last = last || (ref_len == `NOC_MAX_PKT_FLITS - 1);
    dir      = ref_locked ? ref_dir : xy_dir(dx, dy);
    if (!ref_locked && !eff_last) begin
      ref_locked = 1'b1;
      ref_dir    = dir;
    end else if (eff_last) begin
      ref_locked = 1'b0;
    end
    ref_len = eff_last ? 0 : ref_len + 1;
  endtask

  task automatic add_entry(input string name, input coord_t dx, input coord_t dy,
                           input logic last, input payload_t data, input route_dir_e dir);
    table_q.push_back('{dst_x: dx, dst_y: dy, last: last, data: data, dir: dir});
    name_q.push_back(name);
  endtask

  // Table direction overrides the reference when use_exp is set
  task automatic drive_flit(input coord_t dx, input coord_t dy, input logic last,
                            input payload_t data, input logic use_exp,
                            input route_dir_e exp_dir);
    route_dir_e dir;
    logic       eff_last;
    exp_flit_t  e;
    predict_flit(dx, dy, last, dir, eff_last);
    if (use_exp) begin
      dir = exp_dir;
    end
    @(posedge clk_i);
    flit_valid_i <= 1'b1;
    flit_last_i  <= last;
    flit_dst_x_i <= dx;
    flit_dst_y_i <= dy;
    flit_data_i  <= data;
    e.mask    = port_mask_t'(1) << dir;
    e.last    = eff_last;
    e.data    = data;
    e.t_drive = $time;
    sb_q.push_back(e);
    ref_cnt[dir]++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      flit_valid_i <= 1'b0;
      flit_last_i  <= 1'b0;
    end
  endtask

  task automatic collect_outputs(input int n);
    exp_flit_t e;
    int        waited;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      do begin
        @(negedge clk_i);
        waited++;
      end while (out_valid_o == '0 && waited < TIMEOUT_CYC);
      if (out_valid_o == '0 || sb_q.size() == 0) begin
        $display("Timed out at %0t waiting for output flit %0d of %0d", $time, i + 1, n);
        errors++;
        sb_q.delete();
        return;
      end
      e = sb_q.pop_front();
      assert (out_valid_o == e.mask) else begin
        $display("[ERROR] %0t out_valid_o expected %b actual %b", $time, e.mask, out_valid_o);
        errors++;
      end
      assert (out_last_o == e.last) else begin
        $display("[ERROR] %0t out_last_o expected %b actual %b", $time, e.last, out_last_o);
        errors++;
      end
      assert (out_data_o == e.data) else begin
        $display("[ERROR] %0t out_data_o expected %h actual %h", $time, e.data, out_data_o);
        errors++;
      end
      assert (($time - e.t_drive) == LATENCY_NS) else begin
        $display("[ERROR] %0t out_valid_o latency expected %0t actual %0t", $time,
                 LATENCY_NS, $time - e.t_drive);
        errors++;
      end
    end
  endtask

  task automatic compare_counters();
    foreach (ref_cnt[p]) begin
      assert (flit_count_o[p] == flit_cnt_t'(ref_cnt[p])) else begin
        $display("[ERROR] %0t flit_count_o[%0d] expected %0d actual %0d", $time, p,
                 flit_cnt_t'(ref_cnt[p]), flit_count_o[p]);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors > errs_before) begin
      failed_tests++;
      $display("Test %s: FAIL, %0d errors", name, errors - errs_before);
    end else begin
      $display("Test %s: PASS", name);
    end
  endtask

  initial begin
    int         first;
    int         n;
    int         errs_before;
    coord_t     dx;
    coord_t     dy;
    logic       last;
    payload_t   data;
    seed         = 32'hf7ccb59e;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    flit_valid_i = 1'b0;
    flit_last_i  = 1'b0;
    flit_dst_x_i = '0;
    flit_dst_y_i = '0;
    flit_data_i  = '0;
    node_x_i     = NODE_X;
    node_y_i     = NODE_Y;
    clear_model();

    // Single flits to every direction
    add_entry("single_flit", 3, 3, 1'b1, 16'h1001, DIR_EJECT);
    add_entry("single_flit", 3, 1, 1'b1, 16'h1002, DIR_SOUTH);
    add_entry("single_flit", 1, 3, 1'b1, 16'h1003, DIR_WEST);
    add_entry("single_flit", 3, 6, 1'b1, 16'h1004, DIR_NORTH);
    add_entry("single_flit", 6, 3, 1'b1, 16'h1005, DIR_EAST);
    add_entry("single_flit", 5, 0, 1'b1, 16'h1006, DIR_EAST);
    // Body flits point south but stay on the head's east route
    add_entry("route_lock", 6, 3, 1'b0, 16'h2001, DIR_EAST);
    add_entry("route_lock", 3, 0, 1'b0, 16'h2002, DIR_EAST);
    add_entry("route_lock", 3, 1, 1'b1, 16'h2003, DIR_EAST);
    add_entry("route_lock", 1, 3, 1'b1, 16'h2004, DIR_WEST);
    // Flit 4 is cut as last and flit 5 heads a new packet
    add_entry("length_limit", 3, 6, 1'b0, 16'h3001, DIR_NORTH);
    add_entry("length_limit", 0, 0, 1'b0, 16'h3002, DIR_NORTH);
    add_entry("length_limit", 7, 7, 1'b0, 16'h3003, DIR_NORTH);
    add_entry("length_limit", 3, 3, 1'b0, 16'h3004, DIR_NORTH);
    add_entry("length_limit", 1, 1, 1'b0, 16'h3005, DIR_WEST);
    add_entry("length_limit", 6, 6, 1'b1, 16'h3006, DIR_WEST);
    add_entry("back_to_back", 0, 3, 1'b1, 16'h4001, DIR_WEST);
    add_entry("back_to_back", 3, 7, 1'b1, 16'h4002, DIR_NORTH);
    add_entry("back_to_back", 7, 0, 1'b1, 16'h4003, DIR_EAST);

    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    idle_cycles(2);

    first = 0;
    while (first < table_q.size()) begin
      n = 1;
      while (first + n < table_q.size() && name_q[first + n] == name_q[first]) begin
        n++;
      end
      errs_before = errors;
      fork
        begin
          for (int i = first; i < first + n; i++) begin
            drive_flit(table_q[i].dst_x, table_q[i].dst_y, table_q[i].last,
                       table_q[i].data, 1'b1, table_q[i].dir);
          end
          idle_cycles(1);
        end
        collect_outputs(n);
      join
      report_test(name_q[first], errs_before);
      idle_cycles(2);
      first += n;
    end

    // Random destinations, markers and gaps followed by the per-port counts
    // The final flit closes its packet so the route lock is open afterwards
    errs_before = errors;
    fork
      begin
        for (int i = 0; i < NUM_RANDOM; i++) begin
          if (($random(seed) & 3) == 0) begin
            idle_cycles(1);
          end
          dx   = coord_t'($random(seed));
          dy   = coord_t'($random(seed));
          last = (($random(seed) & 3) == 0) || (i == NUM_RANDOM - 1);
          data = payload_t'($random(seed));
          drive_flit(dx, dy, last, data, 1'b0, DIR_EJECT);
        end
        idle_cycles(1);
      end
      collect_outputs(NUM_RANDOM);
    join
    @(negedge clk_i);
    compare_counters();
    report_test("random_counters", errs_before);

    // Reset right after a head flit has locked the route east
    errs_before = errors;
    @(posedge clk_i);
    flit_valid_i <= 1'b1;
    flit_last_i  <= 1'b0;
    flit_dst_x_i <= 6;
    flit_dst_y_i <= 3;
    @(posedge clk_i);
    flit_dst_x_i <= 3;
    flit_dst_y_i <= 0;
    @(posedge clk_i);
    flit_valid_i <= 1'b0;
    arst_n_i     <= 1'b0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    clear_model();
    sb_q.delete();
    @(negedge clk_i);
    compare_counters();
    fork
      begin
        drive_flit(3, 1, 1'b1, 16'h6001, 1'b1, DIR_SOUTH);
        idle_cycles(1);
      end
      collect_outputs(1);
    join
    compare_counters();
    report_test("reset_mid_packet", errs_before);

    if (DUT.u_checker.fail_count != 0) begin
      $display("Bound checker saw %0d assertion failures", DUT.u_checker.fail_count);
      errors += int'(DUT.u_checker.fail_count);
    end

    $display("Tests run %0d, tests failing %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/noc_router_pkg.sv
design/flit_ingress.sv
design/xy_route_select.sv
design/flit_egress.sv
design/noc_router_top.sv
tb/noc_router_checker.sv
tb/noc_router_tb.sv
